/* icache_pkg.sv */
package icache_pkg;

	// Cache geometry
	localparam int LINE_BYTES_W   = 6;
	localparam int TAG_W          = 20;
	localparam int INDEX_W        = 32 - TAG_W - LINE_BYTES_W;
	localparam int OFFSET_W       = LINE_BYTES_W - 2;
	localparam int NUM_LINES      = 2 ** INDEX_W;
	localparam int WORDS_PER_LINE = 2 ** OFFSET_W;

	// AHB transfer types
	localparam logic [1:0] HTRANS_IDLE   = 2'b00;
	localparam logic [1:0] HTRANS_NONSEQ = 2'b10;
	localparam logic [1:0] HTRANS_SEQ    = 2'b11;

	// CPU address split with the tag in the top bits
	typedef struct packed {
		logic [TAG_W-1:0]    tag;
		logic [INDEX_W-1:0]  idx;
		logic [OFFSET_W-1:0] off;
		logic [1:0]          byte_off;
	} fetch_addr_t;

	// Master side of the refill port
	typedef struct packed {
		logic [31:0] haddr;
		logic [1:0]  htrans;
		logic        sel;
	} ahb_req_t;

	typedef struct packed {
		logic [31:0] hrdata;
		logic        hready;
	} ahb_rsp_t;

	// One write into the line array
	typedef struct packed {
		logic                write;
		logic [INDEX_W-1:0]  idx;
		logic [OFFSET_W-1:0] off;
		logic [TAG_W-1:0]    tag;
		logic [31:0]         data;
		logic                valid;
	} line_wr_t;

	// Refill and invalidate sequencing
	typedef enum logic [2:0] {
		IDLE          = 3'd0,
		MEMREAD_FIRST = 3'd1,
		MEMREAD       = 3'd2,
		WAIT_WRITE    = 3'd3,
		WAIT_READ     = 3'd4
	} ctrl_state_t;

endpackage

/* cache_line.sv */
module cache_line
	import icache_pkg::*;
(
	input  logic                clk,
	input  logic                nrst,
	input  logic                we,
	input  line_wr_t            wr,
	input  logic [OFFSET_W-1:0] rd_off,
	output logic [TAG_W-1:0]    rd_tag,
	output logic                rd_valid,
	output logic [31:0]         rd_data
);

	logic [31:0]      data_q [WORDS_PER_LINE];
	logic [TAG_W-1:0] tag_q;
	logic             valid_q;

	// Line valid flag
	always_ff @(posedge clk or negedge nrst) begin
		if (!nrst) begin
			valid_q <= 1'b0;
		end else if (we) begin
			valid_q <= wr.valid;
		end
	end

	always_ff @(posedge clk) begin
		if (we) begin
			tag_q          <= wr.tag;
			data_q[wr.off] <= wr.data;
		end
	end

	// Combinational read port
	assign rd_tag   = tag_q;
	assign rd_valid = valid_q;
	assign rd_data  = data_q[rd_off];

endmodule

/* icache_ctrl.sv */
module icache_ctrl
	import icache_pkg::*;
(
	input  logic                clk,
	input  logic                nrst,

	// CPU fetch side
	input  logic                read,
	input  fetch_addr_t         rdaddr,
	input  logic                hitinvalidate,
	input  fetch_addr_t         ivaddr,
	output logic                rdstall,
	output logic                ivstall,
	output logic [31:0]         rddata,

	// Line array status, selected by the top level
	output fetch_addr_t         req_addr,
	input  logic                sel_valid,
	input  logic [TAG_W-1:0]    sel_tag,
	input  logic [31:0]         sel_data,
	input  logic                iv_valid,
	input  logic [TAG_W-1:0]    iv_tag,

	// Line array access
	output logic [OFFSET_W-1:0] rd_off,
	output line_wr_t            wr,

	// AHB refill port
	output ahb_req_t            ahb,
	input  ahb_rsp_t            ahb_rsp
);

	ctrl_state_t         state;
	logic                req_q;
	logic [OFFSET_W-1:0] acc_off;
	logic [OFFSET_W-1:0] mem_off;
	logic [1:0]          htrans_q;
	logic                sel_q;
	line_wr_t            wr_q;
	logic                need_memread;
	logic                need_invalidate;
	logic                in_burst;

	// Hit and miss decisions
	assign need_memread    = req_q && !(sel_valid && sel_tag == req_addr.tag);
	assign need_invalidate = hitinvalidate && iv_valid && iv_tag == ivaddr.tag;

	assign rdstall = read && (state != IDLE || need_memread);
	assign ivstall = hitinvalidate && (state != IDLE || need_invalidate);
	assign rddata  = rdstall ? 32'd0 : sel_data;

	assign in_burst = state == MEMREAD_FIRST || state == MEMREAD;

	// Refill offset during a burst, request offset otherwise
	assign rd_off = in_burst ? acc_off : req_addr.off;

	// Address phase runs one word ahead of the data phase
	assign mem_off = acc_off + 1'b1;

	assign ahb.haddr  = {req_addr.tag, req_addr.idx, mem_off, 2'b00};
	assign ahb.htrans = htrans_q;
	assign ahb.sel    = sel_q;

	assign wr = wr_q;

	always_ff @(posedge clk or negedge nrst) begin
		if (!nrst) begin
			state    <= IDLE;
			req_q    <= 1'b0;
			req_addr <= '0;
			acc_off  <= '0;
			htrans_q <= HTRANS_IDLE;
			sel_q    <= 1'b0;
			wr_q     <= '0;
		end else begin
			case (state)
				IDLE: begin
					// Invalidate wins over a pending refill
					if (need_invalidate) begin
						wr_q.write <= 1'b1;
						wr_q.idx   <= ivaddr.idx;
						wr_q.off   <= '0;
						wr_q.tag   <= iv_tag;
						wr_q.data  <= '0;
						wr_q.valid <= 1'b0;
						state      <= WAIT_WRITE;
					end else if (need_memread) begin
						acc_off  <= '1;
						htrans_q <= HTRANS_NONSEQ;
						sel_q    <= 1'b1;
						state    <= MEMREAD_FIRST;
					end

					// Hold the missing request so the burst keeps its address
					if (!rdstall && !need_memread) begin
						req_q    <= read;
						req_addr <= rdaddr;
					end
				end

				MEMREAD_FIRST: begin
					if (ahb_rsp.hready) begin
						acc_off  <= acc_off + 1'b1;
						htrans_q <= HTRANS_SEQ;
						state    <= MEMREAD;
					end
				end

				MEMREAD: begin
					if (ahb_rsp.hready) begin
						wr_q.write <= 1'b1;
						wr_q.idx   <= req_addr.idx;
						wr_q.off   <= acc_off;
						wr_q.tag   <= req_addr.tag;
						wr_q.data  <= ahb_rsp.hrdata;

						if (acc_off == '1) begin
							// Line becomes valid with the last word
							wr_q.valid <= 1'b1;
							sel_q      <= 1'b0;
							state      <= WAIT_WRITE;
						end else begin
							wr_q.valid <= 1'b0;
							if (mem_off == '1) begin
								htrans_q <= HTRANS_IDLE;
							end
							acc_off <= acc_off + 1'b1;
						end
					end else begin
						wr_q.write <= 1'b0;
					end
				end

				WAIT_WRITE: begin
					wr_q.write <= 1'b0;
					state      <= WAIT_READ;
				end

				WAIT_READ: begin
					state <= IDLE;
				end

				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

endmodule

/* icache.sv */
module icache
	import icache_pkg::*;
(
	input  logic        clk,
	input  logic        nrst,

	input  logic        read,
	input  fetch_addr_t rdaddr,
	output logic [31:0] rddata,
	output logic        rdstall,

	input  logic        hitinvalidate,
	input  fetch_addr_t ivaddr,
	output logic        ivstall,

	output ahb_req_t    ahb,
	input  ahb_rsp_t    ahb_rsp
);

	logic [TAG_W-1:0]     line_tag   [NUM_LINES];
	logic                 line_valid [NUM_LINES];
	logic [31:0]          line_data  [NUM_LINES];
	logic [NUM_LINES-1:0] line_we;

	line_wr_t            wr;
	logic [OFFSET_W-1:0] rd_off;
	fetch_addr_t         req_addr;
	logic                sel_valid;
	logic [TAG_W-1:0]    sel_tag;
	logic [31:0]         sel_data;
	logic                iv_valid;
	logic [TAG_W-1:0]    iv_tag;

	for (genvar i = 0; i < NUM_LINES; i++) begin : g_line
		// One-hot write enable from the write index
		assign line_we[i] = wr.write && wr.idx == INDEX_W'(i);

		cache_line u_line (
			.clk      (clk),
			.nrst     (nrst),
			.we       (line_we[i]),
			.wr       (wr),
			.rd_off   (rd_off),
			.rd_tag   (line_tag[i]),
			.rd_valid (line_valid[i]),
			.rd_data  (line_data[i])
		);
	end

	// Status of the registered request line
	assign sel_valid = line_valid[req_addr.idx];
	assign sel_tag   = line_tag[req_addr.idx];
	assign sel_data  = line_data[req_addr.idx];

	// Status of the line named by the invalidate
	assign iv_valid = line_valid[ivaddr.idx];
	assign iv_tag   = line_tag[ivaddr.idx];

	icache_ctrl u_ctrl (
		.clk           (clk),
		.nrst          (nrst),
		.read          (read),
		.rdaddr        (rdaddr),
		.hitinvalidate (hitinvalidate),
		.ivaddr        (ivaddr),
		.rdstall       (rdstall),
		.ivstall       (ivstall),
		.rddata        (rddata),
		.req_addr      (req_addr),
		.sel_valid     (sel_valid),
		.sel_tag       (sel_tag),
		.sel_data      (sel_data),
		.iv_valid      (iv_valid),
		.iv_tag        (iv_tag),
		.rd_off        (rd_off),
		.wr            (wr),
		.ahb           (ahb),
		.ahb_rsp       (ahb_rsp)
	);

endmodule

/* ahb_burst_mem.sv */
module ahb_burst_mem
	import icache_pkg::*;
#(
	parameter int SEED = 32'h4daf
)(
	input  logic     clk,
	input  logic     nrst,
	input  ahb_req_t ahb,
	output ahb_rsp_t ahb_rsp
);

	// Word at byte address A reads back as A XOR this mask
	localparam logic [31:0] DATA_MASK = 32'hA5A5_0F0F;

	int          seed;
	logic        pending;
	logic [31:0] dp_addr;
	logic [1:0]  wait_cnt;

	initial begin
		seed = SEED;
	end

	// Tracks one data phase at a time
	always @(posedge clk or negedge nrst) begin
		if (!nrst) begin
			pending  <= 1'b0;
			dp_addr  <= '0;
			wait_cnt <= '0;
		end else if (ahb_rsp.hready) begin
			if (ahb.sel && ahb.htrans[1]) begin
				pending  <= 1'b1;
				dp_addr  <= ahb.haddr;
				// 0 to 3 wait states for the new beat
				wait_cnt <= 2'($random(seed));
			end else begin
				pending <= 1'b0;
			end
		end else begin
			wait_cnt <= wait_cnt - 2'd1;
		end
	end

	assign ahb_rsp.hready = !pending || wait_cnt == 2'd0;

	// Read data only meaningful on the completing cycle
	assign ahb_rsp.hrdata = pending ? ({dp_addr[31:2], 2'b00} ^ DATA_MASK) : 32'd0;

endmodule

/* tb_icache.sv */
module tb_icache
	import icache_pkg::*;
();

	localparam logic [31:0] DATA_MASK = 32'hA5A5_0F0F;
	localparam int NUM_OPS = 200;
	// Worst refill is 16 beats of up to 4 cycles, plus overhead per op
	localparam int CYCLE_LIMIT = (NUM_OPS + 16) * (WORDS_PER_LINE * 4 + 10) * 2;

	logic        clk;
	logic        nrst;
	logic        read;
	fetch_addr_t rdaddr;
	logic [31:0] rddata;
	logic        rdstall;
	logic        hitinvalidate;
	fetch_addr_t ivaddr;
	logic        ivstall;
	ahb_req_t    ahb;
	ahb_rsp_t    ahb_rsp;

	int seed;
	int cycles = 0;

	// Reference model of the tag array
	logic                     model_valid [NUM_LINES];
	logic [TAG_W-1:0]         model_tag   [NUM_LINES];

	// Flags driven by the stimulus tasks
	logic                     exp_miss;
	logic                     first_cycle;
	logic                     req_busy;
	logic                     req_done;
	logic [TAG_W+INDEX_W-1:0] req_line;
	logic [15:0]              burst_start;
	logic                     exp_ivhit;
	logic                     iv_first;
	logic                     iv_busy;
	logic                     post_rst;

	// Bus and fetch monitor state
	logic                     acc_q;
	logic [31:0]              acc_addr;
	logic [31:0]              acc_haddr;
	logic                     hold_q;
	logic [31:0]              hold_addr;
	logic [1:0]               hold_trans;
	logic                     dphase;
	logic                     sel_prev;
	logic [4:0]               addr_cnt;
	logic [4:0]               data_cnt;
	logic [15:0]              burst_cnt;

	icache DUT (
		.clk           (clk),
		.nrst          (nrst),
		.read          (read),
		.rdaddr        (rdaddr),
		.rddata        (rddata),
		.rdstall       (rdstall),
		.hitinvalidate (hitinvalidate),
		.ivaddr        (ivaddr),
		.ivstall       (ivstall),
		.ahb           (ahb),
		.ahb_rsp       (ahb_rsp)
	);

	ahb_burst_mem #(.SEED(32'h4daf)) u_mem (
		.clk     (clk),
		.nrst    (nrst),
		.ahb     (ahb),
		.ahb_rsp (ahb_rsp)
	);

	always #4 clk = ~clk;

	always @(posedge clk or negedge nrst) begin
		if (!nrst) begin
			acc_q      <= 1'b0;
			acc_addr   <= '0;
			acc_haddr  <= '0;
			hold_q     <= 1'b0;
			hold_addr  <= '0;
			hold_trans <= HTRANS_IDLE;
			dphase     <= 1'b0;
			sel_prev   <= 1'b0;
			addr_cnt   <= '0;
			data_cnt   <= '0;
			burst_cnt  <= '0;
		end else begin
			acc_q      <= read && !rdstall;
			acc_addr   <= rdaddr;
			hold_q     <= ahb.htrans != HTRANS_IDLE && !ahb_rsp.hready;
			hold_addr  <= ahb.haddr;
			hold_trans <= ahb.htrans;
			sel_prev   <= ahb.sel;
			if (ahb.htrans[1] && ahb_rsp.hready) begin
				acc_haddr <= ahb.haddr;
				if (ahb.htrans == HTRANS_NONSEQ) begin
					addr_cnt  <= 5'd1;
					burst_cnt <= burst_cnt + 16'd1;
				end else begin
					addr_cnt <= addr_cnt + 5'd1;
				end
			end
			// Data phase follows each accepted address
			if (ahb_rsp.hready) begin
				dphase <= ahb.htrans[1];
			end
			if (ahb.htrans == HTRANS_NONSEQ && ahb_rsp.hready) begin
				data_cnt <= '0;
			end else if (dphase && ahb_rsp.hready) begin
				data_cnt <= data_cnt + 5'd1;
			end
		end
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout: test did not finish within %0d cycles", CYCLE_LIMIT);
			stop_on_error();
		end
	end

	task automatic stop_on_error();
		$display("Errors found");
		$fatal(1, "Stopped at first failing check");
	endtask

	// Fetch data and stall checks
	a_rddata: assert property (@(posedge clk) disable iff (!nrst)
		acc_q && !rdstall |-> rddata == (acc_addr ^ DATA_MASK))
		else begin
			$display("** Error rddata: got %h, expected %h",
				$sampled(rddata), $sampled(acc_addr) ^ DATA_MASK);
			stop_on_error();
		end

	a_rdstall: assert property (@(posedge clk) disable iff (!nrst)
		first_cycle |-> rdstall == exp_miss)
		else begin
			$display("** Error rdstall: got %h, expected %h",
				$sampled(rdstall), $sampled(exp_miss));
			stop_on_error();
		end

	a_hit_quiet: assert property (@(posedge clk) disable iff (!nrst)
		req_busy && !exp_miss |-> !ahb.sel)
		else begin
			$display("Bus activity seen during a read that hits");
			stop_on_error();
		end

	a_burst_count: assert property (@(posedge clk) disable iff (!nrst)
		req_done |-> burst_cnt == burst_start + 16'(exp_miss))
		else begin
			$display("** Error burst_cnt: got %h, expected %h",
				$sampled(burst_cnt), $sampled(burst_start) + 16'($sampled(exp_miss)));
			stop_on_error();
		end

	// Burst shape
	a_first_addr: assert property (@(posedge clk) disable iff (!nrst)
		ahb.htrans == HTRANS_NONSEQ |-> ahb.haddr == {req_line, {LINE_BYTES_W{1'b0}}})
		else begin
			$display("** Error haddr: got %h, expected %h", $sampled(ahb.haddr),
				{$sampled(req_line), {LINE_BYTES_W{1'b0}}});
			stop_on_error();
		end

	a_seq_addr: assert property (@(posedge clk) disable iff (!nrst)
		ahb.htrans == HTRANS_SEQ |-> ahb.haddr == acc_haddr + 32'd4)
		else begin
			$display("** Error haddr: got %h, expected %h",
				$sampled(ahb.haddr), $sampled(acc_haddr) + 32'd4);
			stop_on_error();
		end

	a_hold: assert property (@(posedge clk) disable iff (!nrst)
		hold_q |-> ahb.haddr == hold_addr && ahb.htrans == hold_trans)
		else begin
			$display("** Error haddr/htrans: got %h/%h, expected %h/%h",
				$sampled(ahb.haddr), $sampled(ahb.htrans),
				$sampled(hold_addr), $sampled(hold_trans));
			stop_on_error();
		end

	a_in_line: assert property (@(posedge clk) disable iff (!nrst)
		ahb.htrans != HTRANS_IDLE |-> ahb.sel && ahb.haddr[31:LINE_BYTES_W] == req_line)
		else begin
			$display("** Error haddr: %h outside line %h or sel low",
				$sampled(ahb.haddr), $sampled(req_line));
			stop_on_error();
		end

	a_beat_limit: assert property (@(posedge clk) disable iff (!nrst)
		ahb.htrans == HTRANS_SEQ |-> addr_cnt < 5'd16)
		else begin
			$display("Burst issued more than 16 address phases");
			stop_on_error();
		end

	a_sel_data: assert property (@(posedge clk) disable iff (!nrst)
		dphase |-> ahb.sel)
		else begin
			$display("sel dropped during a data phase");
			stop_on_error();
		end

	a_burst_end: assert property (@(posedge clk) disable iff (!nrst)
		sel_prev && !ahb.sel |-> addr_cnt == 5'd16 && data_cnt == 5'd16 && !dphase)
		else begin
			$display("** Error addr_cnt/data_cnt: got %h/%h, expected 10/10",
				$sampled(addr_cnt), $sampled(data_cnt));
			stop_on_error();
		end

	// Invalidate and reset state
	a_ivstall: assert property (@(posedge clk) disable iff (!nrst)
		iv_first |-> ivstall == exp_ivhit)
		else begin
			$display("** Error ivstall: got %h, expected %h",
				$sampled(ivstall), $sampled(exp_ivhit));
			stop_on_error();
		end

	a_iv_miss: assert property (@(posedge clk) disable iff (!nrst)
		iv_busy && !exp_ivhit |-> !ivstall)
		else begin
			$display("ivstall raised by an invalidate that misses");
			stop_on_error();
		end

	a_reset: assert property (@(posedge clk) disable iff (!nrst)
		post_rst |-> !ahb.sel && ahb.htrans == HTRANS_IDLE)
		else begin
			$display("** Error sel/htrans after reset: got %h/%h, expected 0/0",
				$sampled(ahb.sel), $sampled(ahb.htrans));
			stop_on_error();
		end

	task automatic idle(input int n);
		read = 1'b0;
		repeat (n) @(posedge clk);
		#1;
	endtask

	task automatic do_read(input fetch_addr_t a);
		exp_miss    = !(model_valid[a.idx] && model_tag[a.idx] == a.tag);
		req_line    = {a.tag, a.idx};
		burst_start = burst_cnt;
		req_busy    = 1'b1;
		read        = 1'b1;
		rdaddr      = a;
		@(posedge clk);
		#1 first_cycle = 1'b1;
		@(posedge clk);
		#1 first_cycle = 1'b0;
		@(negedge clk);
		while (rdstall) @(negedge clk);
		@(posedge clk);
		#1;
		req_busy = 1'b0;
		req_done = 1'b1;
		model_valid[a.idx] = 1'b1;
		model_tag[a.idx]   = a.tag;
		@(posedge clk);
		#1 req_done = 1'b0;
	endtask

	task automatic do_invalidate(input fetch_addr_t a);
		// Drop read first so no stale request is held
		idle(1);
		exp_ivhit     = model_valid[a.idx] && model_tag[a.idx] == a.tag;
		iv_busy       = 1'b1;
		iv_first      = 1'b1;
		hitinvalidate = 1'b1;
		ivaddr        = a;
		@(posedge clk);
		#1 iv_first = 1'b0;
		@(negedge clk);
		while (ivstall) @(negedge clk);
		@(posedge clk);
		#1;
		hitinvalidate = 1'b0;
		iv_busy       = 1'b0;
		if (exp_ivhit) begin
			model_valid[a.idx] = 1'b0;
		end
	endtask

	task automatic pick_addr(output fetch_addr_t a);
		logic [31:0] r;
		r = $random(seed);
		// Few tags and indexes so lines get reused and evicted
		a.tag      = 20'h4A000 | 20'(r[1:0]);
		a.idx      = 6'(r[4:2]);
		a.off      = r[11:8];
		a.byte_off = 2'b00;
	endtask

	initial begin
		fetch_addr_t a;
		fetch_addr_t b;
		logic [31:0] r;
		seed          = 32'h4daf;
		clk           = 1'b0;
		nrst          = 1'b0;
		read          = 1'b0;
		rdaddr        = '0;
		hitinvalidate = 1'b0;
		ivaddr        = '0;
		exp_miss      = 1'b0;
		first_cycle   = 1'b0;
		req_busy      = 1'b0;
		req_done      = 1'b0;
		req_line      = '0;
		burst_start   = '0;
		exp_ivhit     = 1'b0;
		iv_first      = 1'b0;
		iv_busy       = 1'b0;
		post_rst      = 1'b0;
		for (int i = 0; i < NUM_LINES; i++) begin
			model_valid[i] = 1'b0;
			model_tag[i]   = '0;
		end
		repeat (2) @(posedge clk);
		#1 nrst = 1'b1;
		post_rst = 1'b1;
		@(posedge clk);
		#1 post_rst = 0;

		// Miss, hit, eviction by another tag, then miss again
		a = '{tag: 20'h12345, idx: 6'd5, off: 4'd3, byte_off: 2'b00};
		do_read(a);
		a.off = 4'd9;
		do_read(a);
		b = a;
		b.tag = 20'h0ABCD;
		do_read(b);
		do_read(a);
		do_invalidate(a);
		do_invalidate(b);
		do_read(a);
		idle(2);

		for (int i = 0; i < NUM_OPS; i++) begin
			r = $random(seed);
			pick_addr(a);
			if (r[2:0] == 3'd0) begin
				do_invalidate(a);
			end else begin
				do_read(a);
			end
			if (r[5:4] == 2'd0) begin
				idle(1);
			end
		end
		idle(2);

		$display("No errors");
		$finish;
	end

endmodule

/* sim.f */
icache_pkg.sv
cache_line.sv
icache_ctrl.sv
icache.sv
ahb_burst_mem.sv
tb_icache.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_icache
FLIST     ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= No errors

.PHONY: all lint sim build clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FLIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
